/* vlog.f */
+incdir+source
source/eeprom_pkg.sv
source/eeprom_if.sv
source/eeprom_bus_sync.sv
source/eeprom_shifter.sv
source/eeprom_control.sv
source/eeprom_array.sv
source/eeprom_top.sv
test/eeprom_clock.sv
test/eeprom_properties.sv
test/eeprom_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the EEPROM testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module eeprom_tb -f vlog.f -o eeprom_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/eeprom_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$log"; then
    exit 0
fi
exit 1

/* test/eeprom_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb;
    localparam int half_cycles = 8;                // sda cycles per scl half-period
    localparam int byte_cycles = 18 * half_cycles; // eight bits and the ack slot
    localparam int cond_cycles = 4 * half_cycles;  // one start, repeated start or stop
    // 48 bytes and 32 bus conditions in all transfers, then reset and the idle gap
    localparam int run_cycles = 48 * byte_cycles + 32 * cond_cycles + 4 + 20;
    localparam int cycle_limit = run_cycles + run_cycles / 5;
    localparam logic [3:0] device_code = 4'b1010;

    logic sda;
    logic rst;
    logic scl_m;
    logic sio_m;
    logic sio;
    logic sio_drive_low;
    logic [7:0] ref_mem [2048];
    int seed = 99645;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    assign sio = sio_m & ~sio_drive_low; // wired-AND bus line

    eeprom_clock clock_gen (
        .sda (sda),
        .rst (rst)
    );

    eeprom_top DUT (
        .sda           (sda),
        .rst           (rst),
        .scl           (scl_m),
        .sio           (sio),
        .sio_drive_low (sio_drive_low)
    );

    bind eeprom_top eeprom_properties props (
        .sda           (sda),
        .rst           (rst),
        .scl           (scl),
        .sio           (sio),
        .sio_drive_low (sio_drive_low)
    );

    always @(posedge sda)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the bus transfers did not end within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [7:0] control_byte(input logic [10:0] addr, input logic rd);
        return {device_code, addr[10:8], rd};
    endfunction

    task automatic half_period();
        repeat (half_cycles) @(negedge sda);
    endtask

    task automatic clock_bit(input logic value, output logic line);
        sio_m = value;
        half_period();
        scl_m = 1'b1;
        half_period();
        line = sio; // end of the high half
        scl_m = 1'b0;
    endtask

    task automatic send_start();
        sio_m = 1'b1;
        half_period();
        scl_m = 1'b1;
        half_period();
        sio_m = 1'b0;
        half_period();
        scl_m = 1'b0;
        half_period();
    endtask

    task automatic send_stop();
        sio_m = 1'b0;
        half_period();
        scl_m = 1'b1;
        half_period();
        sio_m = 1'b1;
        half_period();
        half_period(); // idle bus before the next transfer
    endtask

    task automatic send_byte(input logic [7:0] data, input logic expect_ack);
        logic [7:0] shift;
        logic line;
        shift = data;
        repeat (8)
        begin
            clock_bit(shift[7], line);
            shift = shift << 1;
        end
        clock_bit(1'b1, line);
        checks++;
        assert (line == !expect_ack)
        else
        begin
            errors++;
            $display("Fail sio_ack expected %h got %h", !expect_ack, line);
        end
    endtask

    task automatic read_byte(input logic [7:0] expected, input logic ack);
        logic [7:0] got;
        logic line;
        got = 8'h00;
        repeat (8)
        begin
            clock_bit(1'b1, line);
            got = {got[6:0], line};
        end
        clock_bit(!ack, line); // a low ninth bit asks for the next byte
        checks++;
        assert (got == expected)
        else
        begin
            errors++;
            $display("Fail sio_byte expected %h got %h", expected, got);
        end
    endtask

    task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
        send_start();
        send_byte(control_byte(addr, 1'b0), 1'b1);
        send_byte(addr[7:0], 1'b1);
        send_byte(data, 1'b1);
        send_stop();
        ref_mem[addr] = data;
    endtask

    task automatic read_bytes(input logic [10:0] addr, input int count);
        logic [10:0] a;
        int i;
        a = addr;
        send_start();
        send_byte(control_byte(addr, 1'b0), 1'b1);
        send_byte(addr[7:0], 1'b1);
        send_start();
        send_byte(control_byte(addr, 1'b1), 1'b1);
        for (i = 0; i < count; i++)
        begin
            read_byte(ref_mem[a], i != count - 1);
            a = a + 11'd1;
        end
        send_stop();
    endtask

    // no byte of this transfer may be acknowledged or stored
    task automatic write_wrong_device(input logic [10:0] addr, input logic [7:0] data);
        send_start();
        send_byte({4'b0101, addr[10:8], 1'b0}, 1'b0);
        send_byte(addr[7:0], 1'b0);
        send_byte(data, 1'b0);
        send_stop();
    endtask

    task automatic stop_mid_data(input logic [10:0] addr, input logic [7:0] data);
        logic [7:0] shift;
        logic line;
        shift = data;
        send_start();
        send_byte(control_byte(addr, 1'b0), 1'b1);
        send_byte(addr[7:0], 1'b1);
        repeat (4)
        begin
            clock_bit(shift[7], line);
            shift = shift << 1;
        end
        send_stop();
    endtask

    initial
    begin
        logic [10:0] addr;
        logic [10:0] addr_a;
        logic [10:0] addr_b;
        logic [7:0] data;
        scl_m = 1'b1;
        sio_m = 1'b1;
        ref_mem = '{default: 8'h00}; // the array starts out cleared
        @(negedge rst);
        repeat (20) @(negedge sda);

        addr = 11'($random(seed));
        data = 8'($random(seed));
        write_byte(addr, data);
        read_bytes(addr, 1);

        // same address byte in two blocks
        addr_a = {3'd2, addr[7:0]};
        addr_b = {3'd5, addr[7:0]};
        data = 8'($random(seed));
        write_byte(addr_a, data);
        write_byte(addr_b, ~data);
        read_bytes(addr_a, 1);
        read_bytes(addr_b, 1);

        write_wrong_device(addr_a, ~ref_mem[addr_a]);
        read_bytes(addr_a, 1);

        stop_mid_data(addr, ~ref_mem[addr]);
        read_bytes(addr, 1);

        write_byte(11'h7ff, 8'($random(seed)));
        write_byte(11'h000, 8'($random(seed)));
        read_bytes(11'h7fe, 4); // crosses the top of the array

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/eeprom_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_properties (
    input logic sda,
    input logic rst,
    input logic scl,
    input logic sio,
    input logic sio_drive_low
);
    logic sio_prev;
    logic start_slot; // from a START on the pins until scl falls again

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            sio_prev   <= 1'b1;
            start_slot <= 1'b0;
        end
        else
        begin
            sio_prev <= sio;
            if (!scl)
                start_slot <= 1'b0;
            else if (sio_prev && !sio)
                start_slot <= 1'b1;
        end
    end

    drive_off_in_reset: assert property (@(posedge sda) $past(rst) |-> !sio_drive_low)
        else $error("sio_drive_low was active during reset");

    // the slave only moves sio while scl is low
    stable_while_scl_high: assert property (@(posedge sda) disable iff (rst)
        scl && $past(scl) && !start_slot |-> $stable(sio_drive_low))
        else $error("sio_drive_low changed while scl was high");

    pull_low_with_scl_low: assert property (@(posedge sda) disable iff (rst)
        $rose(sio_drive_low) |-> !scl)
        else $error("sio_drive_low started to pull while scl was high");

endmodule

`default_nettype wire

/* test/eeprom_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_clock (
    output logic sda,
    output logic rst
);
    initial
    begin
        sda = 1'b0;
        forever #10 sda = ~sda; // 20 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (4) @(negedge sda); // covers four rising edges
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* source/eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_top
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic sio,
    output logic sio_drive_low // open-drain enable for the sio pin
);
    bus_event_if ev ();
    byte_link_if link ();

    logic mem_we;
    logic mem_re;
    mem_addr_t mem_addr;
    byte_t mem_wdata;
    byte_t mem_rdata;

    eeprom_bus_sync u_bus_sync (
        .sda (sda),
        .rst (rst),
        .scl (scl),
        .sio (sio),
        .ev  (ev)
    );

    eeprom_shifter u_shifter (
        .sda           (sda),
        .rst           (rst),
        .ev            (ev),
        .link          (link),
        .sio_drive_low (sio_drive_low)
    );

    eeprom_control u_control (
        .sda       (sda),
        .rst       (rst),
        .ev        (ev),
        .link      (link),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    eeprom_array u_array (
        .sda   (sda),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* source/eeprom_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_array
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic we,
    input  logic re,
    input  mem_addr_t addr,
    input  byte_t wdata,
    output byte_t rdata
);
    byte_t mem [`EEPROM_DEPTH];

    // a fresh part reads back all zeros
    initial
    begin
        for (int i = 0; i < `EEPROM_DEPTH; i++)
            mem[i] = '0;
    end

    always @(posedge sda)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    always_ff @(posedge sda)
    begin
        if (re)
            rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* source/eeprom_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_control
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst,
    bus_event_if.sink ev,
    byte_link_if.control link,
    output logic mem_we,
    output logic mem_re,
    output mem_addr_t mem_addr,
    output byte_t mem_wdata,
    input  byte_t mem_rdata
);
    ctrl_state_t state;
    block_t block;
    mem_addr_t addr;
    byte_t wdata;
    logic read_wait; // read data from the array is valid in this cycle
    logic dev_match;

    assign dev_match = (link.rx_byte[7:4] == `EEPROM_DEVICE_CODE);

    assign mem_addr  = addr;
    assign mem_wdata = wdata;

    assign link.send_mode = (state == send_data);
    assign link.tx_load   = read_wait;
    assign link.tx_byte   = mem_rdata;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state           <= idle;
            addr            <= '0;
            link.ack_enable <= 1'b0;
            mem_we          <= 1'b0;
            mem_re          <= 1'b0;
            read_wait       <= 1'b0;
        end
        else
        begin
            mem_we    <= ev.stop && (state == write_pending); // commit only on STOP
            mem_re    <= 1'b0;
            read_wait <= mem_re;
            // the ack covers exactly one slot and the ninth rising edge ends it
            if (ev.scl_rise)
                link.ack_enable <= 1'b0;
            if (ev.start || ev.stop)
            begin
                state           <= idle;
                link.ack_enable <= 1'b0;
            end
            else
            begin
                case (state)
                    idle:
                        if (link.byte_done)
                        begin
                            if (!dev_match)
                                state <= wait_stop;
                            else if (link.rx_byte[0])
                            begin
                                link.ack_enable <= 1'b1;
                                mem_re          <= 1'b1; // first byte from the current address
                                state           <= send_data;
                            end
                            else
                            begin
                                link.ack_enable <= 1'b1;
                                state           <= get_address;
                            end
                        end
                    get_address:
                        if (link.byte_done)
                        begin
                            addr            <= {block, link.rx_byte};
                            link.ack_enable <= 1'b1;
                            state           <= get_data;
                        end
                    get_data:
                        if (link.byte_done)
                        begin
                            link.ack_enable <= 1'b1;
                            state           <= write_pending;
                        end
                    send_data:
                        if (link.ack_seen)
                        begin
                            if (link.master_ack)
                            begin
                                addr   <= addr + mem_addr_t'(1); // wraps at the top of the array
                                mem_re <= 1'b1;
                            end
                            else
                                state <= wait_stop;
                        end
                    default:
                        state <= state; // extra bytes are not acknowledged
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (state == idle && link.byte_done && !link.rx_byte[0])
            block <= link.rx_byte[3:1];
        if (state == get_data && link.byte_done)
            wdata <= link.rx_byte;
    end

endmodule

`default_nettype wire

/* source/eeprom_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_shifter
    import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst,
    bus_event_if.sink ev,
    byte_link_if.shifter link,
    output logic sio_drive_low
);
    logic active;   // between START and STOP
    logic slot_end; // ninth rising edge seen, slot closes on the next fall
    bit_count_t bit_cnt;
    byte_t rx_shift;
    byte_t tx_shift;
    logic data_rise;
    logic ack_rise;
    logic ack_fall;
    logic end_fall;
    logic tx_fall;

    assign data_rise = active && ev.scl_rise && (bit_cnt < 4'd8);
    assign ack_rise  = active && ev.scl_rise && (bit_cnt == 4'd8);
    assign ack_fall  = active && ev.scl_fall && (bit_cnt == 4'd8);
    assign end_fall  = active && ev.scl_fall && slot_end;

    // bits 6 down to 0 of a transmitted byte are put out on these falls
    assign tx_fall = active && ev.scl_fall && link.send_mode
                     && (bit_cnt != 4'd0) && (bit_cnt < 4'd8);

    assign link.rx_byte = rx_shift;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            active         <= 1'b0;
            slot_end       <= 1'b0;
            bit_cnt        <= '0;
            link.byte_done <= 1'b0;
            link.ack_seen  <= 1'b0;
            sio_drive_low  <= 1'b0;
        end
        else
        begin
            link.byte_done <= data_rise && (bit_cnt == 4'd7);
            // while the slave acks its own read command there is no master ack
            link.ack_seen  <= ack_rise && link.send_mode && !link.ack_enable;
            if (ev.start || ev.stop)
            begin
                active        <= ev.start;
                slot_end      <= 1'b0;
                bit_cnt       <= '0;
                sio_drive_low <= 1'b0;
            end
            else
            begin
                if (data_rise)
                    bit_cnt <= bit_cnt + 4'd1;
                if (ack_rise)
                begin
                    bit_cnt  <= '0;
                    slot_end <= 1'b1;
                end
                if (ack_fall)
                    sio_drive_low <= link.ack_enable;
                else if (end_fall)
                begin
                    slot_end      <= 1'b0;
                    sio_drive_low <= link.send_mode && !tx_shift[7]; // MSB of next byte
                end
                else if (tx_fall)
                    sio_drive_low <= !tx_shift[6];
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (data_rise)
            rx_shift <= {rx_shift[6:0], ev.sio_level};
        if (ack_rise)
            link.master_ack <= !ev.sio_level; // low in the ninth slot is an ack
        if (link.tx_load)
            tx_shift <= link.tx_byte;
        else if (tx_fall)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

endmodule

`default_nettype wire

/* source/eeprom_bus_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_bus_sync (
    input  logic sda,
    input  logic rst,
    input  logic scl,
    input  logic sio,
    bus_event_if.source ev
);
    logic [`EEPROM_SYNC_STAGES-1:0] scl_sync;
    logic [`EEPROM_SYNC_STAGES-1:0] sio_sync;
    logic scl_s;
    logic sio_s;
    logic scl_prev;
    logic sio_prev;

    assign scl_s = scl_sync[`EEPROM_SYNC_STAGES-1];
    assign sio_s = sio_sync[`EEPROM_SYNC_STAGES-1];

    // the previous value is the level that lines up with the registered strobes
    assign ev.sio_level = sio_prev;

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_sync    <= '1; // idle bus is high on both wires
            sio_sync    <= '1;
            scl_prev    <= 1'b1;
            sio_prev    <= 1'b1;
            ev.scl_rise <= 1'b0;
            ev.scl_fall <= 1'b0;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
        end
        else
        begin
            scl_sync    <= {scl_sync[`EEPROM_SYNC_STAGES-2:0], scl};
            sio_sync    <= {sio_sync[`EEPROM_SYNC_STAGES-2:0], sio};
            scl_prev    <= scl_s;
            sio_prev    <= sio_s;
            ev.scl_rise <= scl_s && !scl_prev;
            ev.scl_fall <= !scl_s && scl_prev;
            // sio may only move while scl is high for a bus condition
            ev.start    <= scl_s && scl_prev && sio_prev && !sio_s;
            ev.stop     <= scl_s && scl_prev && !sio_prev && sio_s;
        end
    end

endmodule

`default_nettype wire

/* source/eeprom_if.sv */
`timescale 1ns/1ps
`default_nettype none

// bus conditions, all strobes aligned with sio_level
interface bus_event_if;
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sio_level;

    modport source (output start, stop, scl_rise, scl_fall, sio_level);
    modport sink (input start, stop, scl_rise, scl_fall, sio_level);
endinterface

interface byte_link_if
    import eeprom_pkg::*;
();
    byte_t rx_byte;
    logic byte_done;
    logic master_ack;
    logic ack_seen;
    logic ack_enable;
    logic send_mode;
    logic tx_load;
    byte_t tx_byte;

    modport shifter (
        output rx_byte, byte_done, master_ack, ack_seen,
        input ack_enable, send_mode, tx_load, tx_byte
    );
    modport control (
        input rx_byte, byte_done, master_ack, ack_seen,
        output ack_enable, send_mode, tx_load, tx_byte
    );
endinterface

`default_nettype wire

/* source/eeprom_pkg.sv */
`default_nettype none

`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`EEPROM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`EEPROM_BLOCK_W-1:0] block_t;
    typedef logic [3:0] bit_count_t; // bit slots seen in the current byte

    // idle also covers the control byte that follows a START
    typedef enum logic [2:0] {
        idle,
        get_address,
        get_data,
        write_pending,
        send_data,
        wait_stop
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/eeprom_consts.svh */
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// upper nibble of every control byte this device answers to
`define EEPROM_DEVICE_CODE 4'b1010

`define EEPROM_DEPTH 2048
`define EEPROM_ADDR_W 11

// block select bits in the control byte, which form the upper address bits
`define EEPROM_BLOCK_W 3

`define EEPROM_SYNC_STAGES 2 // flops per input line before edge detection

`endif
